// File: design/zynq_shell_pkg.sv
package zynq_shell_pkg;

   // the host slave port drops the top two bits of the 32-bit address
   localparam int host_addr_width = 30;

   // core physical addresses and host DRAM addresses share one width
   localparam int core_addr_width = 32;

   // register words follow the width of the host control bus
   localparam int csr_word_width = 32;

   typedef logic [host_addr_width-1:0] host_addr_t;
   typedef logic [core_addr_width-1:0] core_addr_t;
   typedef logic [csr_word_width-1:0]  csr_word_t;
   typedef logic [2:0]                 csr_idx_t;

   // register map as seen from the host, one word per index
   // indices 3 to 7 are read-only and ignore writes
   typedef enum csr_idx_t
   {
      csr_run        = 3'd0,
      csr_dram_alloc = 3'd1,
      csr_dram_base  = 3'd2,
      csr_status     = 3'd3,
      csr_prof0      = 3'd4,
      csr_prof1      = 3'd5,
      csr_prof2      = 3'd6,
      csr_prof3      = 3'd7
   } csr_idx_e;

   // cached DRAM starts here in the core's physical map
   localparam core_addr_t core_dram_base = 32'h8000_0000;

   // host addresses above this fold down into the core's local space
   // and the same value undoes the window offset by XOR
   localparam core_addr_t host_high_window = 32'h2000_0000;

   // one profiler bit per DRAM region, read back as four register words
   localparam int num_regions = 128;

endpackage

// File: design/shell_csr_ctrl.sv
`timescale 1ns/100ps

module shell_csr_ctrl
   (
    input  logic                                    aclk_i
   ,input  logic                                    rst_n_i
   ,input  logic                                    csr_we_i
   ,input  zynq_shell_pkg::csr_idx_t                csr_waddr_i
   ,input  zynq_shell_pkg::csr_word_t               csr_wdata_i
   ,input  zynq_shell_pkg::csr_idx_t                csr_raddr_i
   ,input  logic [zynq_shell_pkg::num_regions-1:0]  profile_i
   ,input  logic                                    wr_over_limit_i
   ,input  logic                                    rd_over_limit_i
   ,output zynq_shell_pkg::csr_word_t               csr_rdata_o
   ,output zynq_shell_pkg::core_addr_t              dram_base_o
   ,output logic                                    core_reset_o
   );

   // only bit 0 of the run register is kept and the rest reads as zero
   logic                        run_r;
   zynq_shell_pkg::csr_word_t   alloc_r;
   zynq_shell_pkg::core_addr_t  base_r;
   logic                        run_set;
   logic                        run_nxt;
   logic                        core_reset_r;

   // a write to the run index this cycle decides the run bit of the next cycle
   assign run_set = csr_we_i && (csr_waddr_i == zynq_shell_pkg::csr_run);
   assign run_nxt = run_set ? csr_wdata_i[0] : run_r;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         run_r   <= 1'b0;
         alloc_r <= '0;
         base_r  <= '0;
      end
      else if (csr_we_i)
      begin
         // status and profiler words are driven by the datapath and ignore writes
         case (csr_waddr_i)
            zynq_shell_pkg::csr_run:        run_r   <= csr_wdata_i[0];
            zynq_shell_pkg::csr_dram_alloc: alloc_r <= csr_wdata_i;
            zynq_shell_pkg::csr_dram_base:  base_r  <= csr_wdata_i;
            default:                        ;
         endcase
      end
   end

   // the core leaves reset in the cycle right after run is written to 1
   // so the flop follows the next value of the run bit, not the current one
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         core_reset_r <= 1'b1;
      else
         core_reset_r <= ~run_nxt;
   end

   assign core_reset_o = core_reset_r;
   assign dram_base_o  = base_r;

   // host reads are combinational on the read index
   always_comb
   begin
      case (csr_raddr_i)
         zynq_shell_pkg::csr_run:        csr_rdata_o = {31'b0, run_r};
         zynq_shell_pkg::csr_dram_alloc: csr_rdata_o = alloc_r;
         zynq_shell_pkg::csr_dram_base:  csr_rdata_o = base_r;
         zynq_shell_pkg::csr_status:     csr_rdata_o = {30'b0, rd_over_limit_i, wr_over_limit_i};
         zynq_shell_pkg::csr_prof0:      csr_rdata_o = profile_i[31:0];
         zynq_shell_pkg::csr_prof1:      csr_rdata_o = profile_i[63:32];
         zynq_shell_pkg::csr_prof2:      csr_rdata_o = profile_i[95:64];
         default:                        csr_rdata_o = profile_i[127:96];
      endcase
   end

   // while run is 0 the core must be held in reset on the following cycle
   // unless the host writes a 1 to the run index in that same cycle
   assert property (@(posedge aclk_i) disable iff (!rst_n_i)
                    (!run_r && !(csr_we_i && (csr_waddr_i == zynq_shell_pkg::csr_run)
                                 && csr_wdata_i[0]))
                    |=> core_reset_o);

endmodule

// File: design/host_addr_xlate.sv
`timescale 1ns/100ps

module host_addr_xlate
   (
    input  logic                        aclk_i
   ,input  logic                        rst_n_i
   ,input  zynq_shell_pkg::host_addr_t  host_awaddr_i
   ,input  logic                        host_awvalid_i
   ,input  zynq_shell_pkg::host_addr_t  host_araddr_i
   ,input  logic                        host_arvalid_i
   ,output zynq_shell_pkg::core_addr_t  core_awaddr_o
   ,output logic                        core_awvalid_o
   ,output zynq_shell_pkg::core_addr_t  core_araddr_o
   ,output logic                        core_arvalid_o
   );

   // the lower host window lands on core DRAM and the upper one on local space
   // both are a single XOR once the window is known
   function automatic zynq_shell_pkg::core_addr_t fold_addr
      (input zynq_shell_pkg::host_addr_t addr);
      zynq_shell_pkg::core_addr_t wide;
      wide = zynq_shell_pkg::core_addr_t'(addr);
      // the boundary value itself still belongs to the DRAM window
      if (wide > zynq_shell_pkg::host_high_window)
         fold_addr = wide ^ zynq_shell_pkg::host_high_window;
      else
         fold_addr = wide ^ zynq_shell_pkg::core_dram_base;
   endfunction

   zynq_shell_pkg::core_addr_t  awaddr_r;
   zynq_shell_pkg::core_addr_t  araddr_r;
   logic                        awvalid_r;
   logic                        arvalid_r;

   // the address registers load every cycle and only count while their strobe is up
   always_ff @(posedge aclk_i)
   begin
      awaddr_r <= fold_addr(host_awaddr_i);
      araddr_r <= fold_addr(host_araddr_i);
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         awvalid_r <= 1'b0;
         arvalid_r <= 1'b0;
      end
      else
      begin
         awvalid_r <= host_awvalid_i;
         arvalid_r <= host_arvalid_i;
      end
   end

   assign core_awaddr_o  = awaddr_r;
   assign core_awvalid_o = awvalid_r;
   assign core_araddr_o  = araddr_r;
   assign core_arvalid_o = arvalid_r;

   // each core-side strobe repeats the host strobe of the previous cycle
   assert property (@(posedge aclk_i) disable iff (!rst_n_i)
                    core_awvalid_o == $past(host_awvalid_i));
   assert property (@(posedge aclk_i) disable iff (!rst_n_i)
                    core_arvalid_o == $past(host_arvalid_i));

endmodule

// File: design/dram_addr_map.sv
`timescale 1ns/100ps

module dram_addr_map
   #(
    // accesses at or above this offset into core DRAM are flagged
    parameter zynq_shell_pkg::core_addr_t mem_limit_p = 32'h0780_0000
   )
   (
    input  logic                        aclk_i
   ,input  logic                        rst_n_i
   ,input  logic                        clear_i
   ,input  zynq_shell_pkg::core_addr_t  dram_base_i
   ,input  zynq_shell_pkg::core_addr_t  req_awaddr_i
   ,input  logic                        req_awvalid_i
   ,input  zynq_shell_pkg::core_addr_t  req_araddr_i
   ,input  logic                        req_arvalid_i
   ,output zynq_shell_pkg::core_addr_t  dram_awaddr_o
   ,output logic                        dram_awvalid_o
   ,output zynq_shell_pkg::core_addr_t  dram_araddr_o
   ,output logic                        dram_arvalid_o
   ,output logic                        wr_over_limit_o
   ,output logic                        rd_over_limit_o
   );

   // offset into core DRAM, XOR works as a subtract for addresses in that range
   zynq_shell_pkg::core_addr_t  aw_offset;
   zynq_shell_pkg::core_addr_t  ar_offset;
   zynq_shell_pkg::core_addr_t  awaddr_r;
   zynq_shell_pkg::core_addr_t  araddr_r;
   logic                        awvalid_r;
   logic                        arvalid_r;
   logic                        wr_over_r;
   logic                        rd_over_r;

   assign aw_offset = req_awaddr_i ^ zynq_shell_pkg::core_dram_base;
   assign ar_offset = req_araddr_i ^ zynq_shell_pkg::core_dram_base;

   // relocated onto the buffer the host allocated, wrapping at 2^32
   always_ff @(posedge aclk_i)
   begin
      awaddr_r <= aw_offset + dram_base_i;
      araddr_r <= ar_offset + dram_base_i;
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         awvalid_r <= 1'b0;
         arvalid_r <= 1'b0;
      end
      else
      begin
         awvalid_r <= req_awvalid_i;
         arvalid_r <= req_arvalid_i;
      end
   end

   // the flags stay up until the core goes back into reset
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_over_r <= 1'b0;
         rd_over_r <= 1'b0;
      end
      else if (clear_i)
      begin
         wr_over_r <= 1'b0;
         rd_over_r <= 1'b0;
      end
      else
      begin
         wr_over_r <= wr_over_r | (req_awvalid_i && (aw_offset >= mem_limit_p));
         rd_over_r <= rd_over_r | (req_arvalid_i && (ar_offset >= mem_limit_p));
      end
   end

   assign dram_awaddr_o   = awaddr_r;
   assign dram_awvalid_o  = awvalid_r;
   assign dram_araddr_o   = araddr_r;
   assign dram_arvalid_o  = arvalid_r;
   assign wr_over_limit_o = wr_over_r;
   assign rd_over_limit_o = rd_over_r;

   // a sticky flag may only drop after a cycle with the clear held high
   assert property (@(posedge aclk_i) disable iff (!rst_n_i)
                    $fell(wr_over_limit_o) |-> $past(clear_i));
   assert property (@(posedge aclk_i) disable iff (!rst_n_i)
                    $fell(rd_over_limit_o) |-> $past(clear_i));

endmodule

// File: design/mem_profiler.sv
`timescale 1ns/100ps

module mem_profiler
   #(
    // lowest address bit of the region index, 23 gives 8 MiB regions
    parameter int region_lsb_p = 23
   )
   (
    input  logic                                    aclk_i
   ,input  logic                                    rst_n_i
   ,input  logic                                    clear_i
   ,input  zynq_shell_pkg::core_addr_t              req_awaddr_i
   ,input  logic                                    req_awvalid_i
   ,input  zynq_shell_pkg::core_addr_t              req_araddr_i
   ,input  logic                                    req_arvalid_i
   ,output logic [zynq_shell_pkg::num_regions-1:0]  profile_o
   );

   localparam int region_bits_lp = $clog2(zynq_shell_pkg::num_regions);

   logic [zynq_shell_pkg::num_regions-1:0]  aw_hit;
   logic [zynq_shell_pkg::num_regions-1:0]  ar_hit;
   logic [zynq_shell_pkg::num_regions-1:0]  profile_r;

   // one-hot region of each channel, empty when that channel is idle
   always_comb
   begin
      aw_hit = '0;
      ar_hit = '0;
      if (req_awvalid_i)
         aw_hit[req_awaddr_i[region_lsb_p +: region_bits_lp]] = 1'b1;
      if (req_arvalid_i)
         ar_hit[req_araddr_i[region_lsb_p +: region_bits_lp]] = 1'b1;
   end

   // a write and a read in the same cycle both leave their mark
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         profile_r <= '0;
      else if (clear_i)
         profile_r <= '0;
      else
         profile_r <= profile_r | aw_hit | ar_hit;
   end

   assign profile_o = profile_r;

endmodule

// File: design/zynq_shell_top.sv
`timescale 1ns/100ps

module zynq_shell_top
   #(
    parameter zynq_shell_pkg::core_addr_t mem_limit_p  = 32'h0780_0000
   ,parameter int                         region_lsb_p = 23
   )
   (
    input  logic                        aclk_i
   ,input  logic                        rst_n_i
   // host register bus
   ,input  logic                        csr_we_i
   ,input  zynq_shell_pkg::csr_idx_t    csr_waddr_i
   ,input  zynq_shell_pkg::csr_word_t   csr_wdata_i
   ,input  zynq_shell_pkg::csr_idx_t    csr_raddr_i
   ,output zynq_shell_pkg::csr_word_t   csr_rdata_o
   // host accesses into the core
   ,input  zynq_shell_pkg::host_addr_t  host_awaddr_i
   ,input  logic                        host_awvalid_i
   ,input  zynq_shell_pkg::host_addr_t  host_araddr_i
   ,input  logic                        host_arvalid_i
   ,output zynq_shell_pkg::core_addr_t  core_awaddr_o
   ,output logic                        core_awvalid_o
   ,output zynq_shell_pkg::core_addr_t  core_araddr_o
   ,output logic                        core_arvalid_o
   // core DRAM requests and their host DRAM addresses
   ,input  zynq_shell_pkg::core_addr_t  dram_req_awaddr_i
   ,input  logic                        dram_req_awvalid_i
   ,input  zynq_shell_pkg::core_addr_t  dram_req_araddr_i
   ,input  logic                        dram_req_arvalid_i
   ,output zynq_shell_pkg::core_addr_t  dram_awaddr_o
   ,output logic                        dram_awvalid_o
   ,output zynq_shell_pkg::core_addr_t  dram_araddr_o
   ,output logic                        dram_arvalid_o
   ,output logic                        core_reset_o
   );

   zynq_shell_pkg::core_addr_t              dram_base;
   logic                                    core_reset;
   logic                                    wr_over_limit;
   logic                                    rd_over_limit;
   logic [zynq_shell_pkg::num_regions-1:0]  profile;

   // the run bit also clears the profiler and the flags, so a new program
   // starts with a clean view of its memory use
   assign core_reset_o = core_reset;

   shell_csr_ctrl csr
      (.aclk_i          (aclk_i)
      ,.rst_n_i         (rst_n_i)
      ,.csr_we_i        (csr_we_i)
      ,.csr_waddr_i     (csr_waddr_i)
      ,.csr_wdata_i     (csr_wdata_i)
      ,.csr_raddr_i     (csr_raddr_i)
      ,.profile_i       (profile)
      ,.wr_over_limit_i (wr_over_limit)
      ,.rd_over_limit_i (rd_over_limit)
      ,.csr_rdata_o     (csr_rdata_o)
      ,.dram_base_o     (dram_base)
      ,.core_reset_o    (core_reset)
      );

   host_addr_xlate xlate
      (.aclk_i         (aclk_i)
      ,.rst_n_i        (rst_n_i)
      ,.host_awaddr_i  (host_awaddr_i)
      ,.host_awvalid_i (host_awvalid_i)
      ,.host_araddr_i  (host_araddr_i)
      ,.host_arvalid_i (host_arvalid_i)
      ,.core_awaddr_o  (core_awaddr_o)
      ,.core_awvalid_o (core_awvalid_o)
      ,.core_araddr_o  (core_araddr_o)
      ,.core_arvalid_o (core_arvalid_o)
      );

   dram_addr_map #(.mem_limit_p(mem_limit_p)) dram_map
      (.aclk_i          (aclk_i)
      ,.rst_n_i         (rst_n_i)
      ,.clear_i         (core_reset)
      ,.dram_base_i     (dram_base)
      ,.req_awaddr_i    (dram_req_awaddr_i)
      ,.req_awvalid_i   (dram_req_awvalid_i)
      ,.req_araddr_i    (dram_req_araddr_i)
      ,.req_arvalid_i   (dram_req_arvalid_i)
      ,.dram_awaddr_o   (dram_awaddr_o)
      ,.dram_awvalid_o  (dram_awvalid_o)
      ,.dram_araddr_o   (dram_araddr_o)
      ,.dram_arvalid_o  (dram_arvalid_o)
      ,.wr_over_limit_o (wr_over_limit)
      ,.rd_over_limit_o (rd_over_limit)
      );

   mem_profiler #(.region_lsb_p(region_lsb_p)) profiler
      (.aclk_i        (aclk_i)
      ,.rst_n_i       (rst_n_i)
      ,.clear_i       (core_reset)
      ,.req_awaddr_i  (dram_req_awaddr_i)
      ,.req_awvalid_i (dram_req_awvalid_i)
      ,.req_araddr_i  (dram_req_araddr_i)
      ,.req_arvalid_i (dram_req_arvalid_i)
      ,.profile_o     (profile)
      );

endmodule

// File: verification/zynq_shell_tb.sv
`timescale 1ns/100ps

module zynq_shell_tb;

   // 120 MiB limit and 8 MiB profiler regions, handed down to the DUT
   localparam logic [31:0] mem_limit_c  = 32'h0780_0000;
   localparam int          region_lsb_c = 23;
   localparam logic [31:0] dram_start_c = 32'h8000_0000;
   localparam logic [31:0] window_c     = 32'h2000_0000;
   localparam int          max_cycles_c = 2000;

   // kinds of result the reference function can produce
   localparam int kind_host   = 0;
   localparam int kind_dram   = 1;
   localparam int kind_limit  = 2;
   localparam int kind_region = 3;

   logic        aclk;
   logic        rst_n;
   logic        csr_we;
   logic [2:0]  csr_waddr;
   logic [31:0] csr_wdata;
   logic [2:0]  csr_raddr;
   logic [31:0] csr_rdata;
   logic [29:0] host_awaddr;
   logic        host_awvalid;
   logic [29:0] host_araddr;
   logic        host_arvalid;
   logic [31:0] core_awaddr;
   logic        core_awvalid;
   logic [31:0] core_araddr;
   logic        core_arvalid;
   logic [31:0] dram_req_awaddr;
   logic        dram_req_awvalid;
   logic [31:0] dram_req_araddr;
   logic        dram_req_arvalid;
   logic [31:0] dram_awaddr;
   logic        dram_awvalid;
   logic [31:0] dram_araddr;
   logic        dram_arvalid;
   logic        core_reset;

   // the compare process fills in the expected outputs for the next cycle
   logic        exp_host_awv;
   logic        exp_host_arv;
   logic        exp_dram_awv;
   logic        exp_dram_arv;
   logic [31:0] exp_host_aw;
   logic [31:0] exp_host_ar;
   logic [31:0] exp_dram_aw;
   logic [31:0] exp_dram_ar;

   logic [15:0]  lfsr_q = 16'd11682;
   logic [31:0]  cur_base = '0;
   logic [127:0] exp_profile;
   logic [1:0]   exp_status;
   string        cur_test = "none";
   int           test_errors = 0;
   int           total_errors = 0;
   int           tests_run = 0;
   int           tests_failed = 0;
   int           cycles = 0;

   zynq_shell_top #(.mem_limit_p(mem_limit_c), .region_lsb_p(region_lsb_c)) UUT
      (.aclk_i             (aclk)
      ,.rst_n_i            (rst_n)
      ,.csr_we_i           (csr_we)
      ,.csr_waddr_i        (csr_waddr)
      ,.csr_wdata_i        (csr_wdata)
      ,.csr_raddr_i        (csr_raddr)
      ,.csr_rdata_o        (csr_rdata)
      ,.host_awaddr_i      (host_awaddr)
      ,.host_awvalid_i     (host_awvalid)
      ,.host_araddr_i      (host_araddr)
      ,.host_arvalid_i     (host_arvalid)
      ,.core_awaddr_o      (core_awaddr)
      ,.core_awvalid_o     (core_awvalid)
      ,.core_araddr_o      (core_araddr)
      ,.core_arvalid_o     (core_arvalid)
      ,.dram_req_awaddr_i  (dram_req_awaddr)
      ,.dram_req_awvalid_i (dram_req_awvalid)
      ,.dram_req_araddr_i  (dram_req_araddr)
      ,.dram_req_arvalid_i (dram_req_arvalid)
      ,.dram_awaddr_o      (dram_awaddr)
      ,.dram_awvalid_o     (dram_awvalid)
      ,.dram_araddr_o      (dram_araddr)
      ,.dram_arvalid_o     (dram_arvalid)
      ,.core_reset_o       (core_reset)
      );

   initial
   begin
      aclk = 1'b0;
      forever #5 aclk = ~aclk;
   end

   // 16-bit Galois LFSR with taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_q[0]};
         lfsr_q = lfsr_next(lfsr_q);
      end
      return v;
   endfunction

   // expected host fold, DRAM relocation, over-limit decision or region index
   function automatic logic [31:0] ref_model(input int kind, input logic [31:0] addr,
                                             input logic [31:0] base);
      case (kind)
         kind_host:  ref_model = (addr > window_c) ? (addr ^ window_c) : (addr ^ dram_start_c);
         kind_dram:  ref_model = (addr ^ dram_start_c) + base;
         kind_limit: ref_model = {31'b0, (addr ^ dram_start_c) >= mem_limit_c};
         default:    ref_model = {25'b0, addr[region_lsb_c +: 7]};
      endcase
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("MISMATCH %s %s: expected %h actual %h", cur_test, what, exp, act);
         test_errors++;
         total_errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      $display("test %s: %0d errors", cur_test, test_errors);
   endtask

   task automatic csr_write(input logic [2:0] idx, input logic [31:0] data);
      @(posedge aclk);
      csr_we    <= 1'b1;
      csr_waddr <= idx;
      csr_wdata <= data;
      @(posedge aclk);
      csr_we    <= 1'b0;
   endtask

   // the read port is combinational, so the word is sampled mid-cycle
   task automatic csr_expect(input string what, input logic [2:0] idx, input logic [31:0] exp);
      @(posedge aclk);
      csr_raddr <= idx;
      @(negedge aclk);
      check_value(what, exp, csr_rdata);
   endtask

   task automatic drive_dram(input logic [31:0] aw, input logic awv,
                             input logic [31:0] ar, input logic arv);
      @(posedge aclk);
      dram_req_awaddr  <= aw;
      dram_req_awvalid <= awv;
      dram_req_araddr  <= ar;
      dram_req_arvalid <= arv;
   endtask

   // outputs are compared one cycle after the inputs that caused them
   always @(negedge aclk)
   begin
      if (!rst_n)
      begin
         exp_host_awv = 1'b0;
         exp_host_arv = 1'b0;
         exp_dram_awv = 1'b0;
         exp_dram_arv = 1'b0;
      end
      else
      begin
         check_value("core_awvalid", exp_host_awv, core_awvalid);
         check_value("core_arvalid", exp_host_arv, core_arvalid);
         check_value("dram_awvalid", exp_dram_awv, dram_awvalid);
         check_value("dram_arvalid", exp_dram_arv, dram_arvalid);
         if (exp_host_awv)
            check_value("core_awaddr", exp_host_aw, core_awaddr);
         if (exp_host_arv)
            check_value("core_araddr", exp_host_ar, core_araddr);
         if (exp_dram_awv)
            check_value("dram_awaddr", exp_dram_aw, dram_awaddr);
         if (exp_dram_arv)
            check_value("dram_araddr", exp_dram_ar, dram_araddr);
         exp_host_awv = host_awvalid;
         exp_host_arv = host_arvalid;
         exp_dram_awv = dram_req_awvalid;
         exp_dram_arv = dram_req_arvalid;
         exp_host_aw  = ref_model(kind_host, {2'b00, host_awaddr}, '0);
         exp_host_ar  = ref_model(kind_host, {2'b00, host_araddr}, '0);
         exp_dram_aw  = ref_model(kind_dram, dram_req_awaddr, cur_base);
         exp_dram_ar  = ref_model(kind_dram, dram_req_araddr, cur_base);
      end
   end

   // the whole run takes a few hundred cycles and the limit leaves ample margin
   always @(posedge aclk)
   begin
      cycles++;
      if (cycles >= max_cycles_c)
      begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles_c);
         $display("tests failed");
         $finish;
      end
   end

   initial
   begin
      logic [31:0] a;
      logic [31:0] b;
      logic        av;
      logic        bv;
      rst_n            <= 1'b0;
      csr_we           <= 1'b0;
      csr_waddr        <= '0;
      csr_wdata        <= '0;
      csr_raddr        <= '0;
      host_awaddr      <= '0;
      host_awvalid     <= 1'b0;
      host_araddr      <= '0;
      host_arvalid     <= 1'b0;
      dram_req_awaddr  <= '0;
      dram_req_awvalid <= 1'b0;
      dram_req_araddr  <= '0;
      dram_req_arvalid <= 1'b0;
      repeat (10) @(posedge aclk);
      rst_n <= 1'b1;

      start_test("reset and run");
      for (int i = 0; i < 8; i++)
         csr_expect("register after reset", i[2:0], '0);
      check_value("core_reset after reset", 1'b1, core_reset);
      csr_write(zynq_shell_pkg::csr_run, 32'd1);
      @(negedge aclk);
      check_value("core_reset after run", 1'b0, core_reset);
      finish_test();

      start_test("register readback");
      a = random_bits(32);
      b = random_bits(32);
      csr_write(zynq_shell_pkg::csr_dram_alloc, a);
      csr_write(zynq_shell_pkg::csr_dram_base, b);
      // read-only words must keep their reset value
      for (int i = 3; i < 8; i++)
         csr_write(i[2:0], random_bits(32));
      csr_expect("run", zynq_shell_pkg::csr_run, 32'd1);
      csr_expect("dram_alloc", zynq_shell_pkg::csr_dram_alloc, a);
      csr_expect("dram_base", zynq_shell_pkg::csr_dram_base, b);
      for (int i = 3; i < 8; i++)
         csr_expect("read-only word", i[2:0], '0);
      finish_test();

      start_test("host translation");
      for (int i = 0; i < 50; i++)
      begin
         // the first two cycles hit the window boundary on both channels
         a = (i == 0) ? window_c : (i == 1) ? window_c + 1 : random_bits(30);
         b = (i == 0) ? window_c + 1 : (i == 1) ? window_c : random_bits(30);
         @(posedge aclk);
         host_awaddr  <= a[29:0];
         host_awvalid <= 1'b1;
         host_araddr  <= b[29:0];
         host_arvalid <= 1'b1;
      end
      @(posedge aclk);
      host_awvalid <= 1'b0;
      host_arvalid <= 1'b0;
      repeat (2) @(posedge aclk);
      finish_test();

      start_test("dram mapping");
      a = random_bits(32);
      csr_write(zynq_shell_pkg::csr_dram_base, a);
      cur_base = a;
      for (int i = 0; i < 50; i++)
         drive_dram(random_bits(32), random_bits(1), random_bits(32), random_bits(1));
      drive_dram('0, 1'b0, '0, 1'b0);
      repeat (2) @(posedge aclk);
      finish_test();

      start_test("over limit");
      // a reset pulse of the core clears flags left by the random traffic
      csr_write(zynq_shell_pkg::csr_run, 32'd0);
      csr_write(zynq_shell_pkg::csr_run, 32'd1);
      csr_expect("status cleared", zynq_shell_pkg::csr_status, '0);
      a = dram_start_c | mem_limit_c;
      b = (dram_start_c | mem_limit_c) - 4;
      exp_status = {ref_model(kind_limit, b, '0) != 0, ref_model(kind_limit, a, '0) != 0};
      drive_dram(a, 1'b1, b, 1'b1);
      drive_dram('0, 1'b0, '0, 1'b0);
      csr_expect("status at limit", zynq_shell_pkg::csr_status, {30'b0, exp_status});
      b = (dram_start_c | mem_limit_c) + 4;
      exp_status[1] = exp_status[1] | (ref_model(kind_limit, b, '0) != 0);
      drive_dram('0, 1'b0, b, 1'b1);
      drive_dram('0, 1'b0, '0, 1'b0);
      csr_expect("status above limit", zynq_shell_pkg::csr_status, {30'b0, exp_status});
      csr_write(zynq_shell_pkg::csr_run, 32'd0);
      csr_expect("status after core reset", zynq_shell_pkg::csr_status, '0);
      finish_test();

      start_test("profiler");
      csr_write(zynq_shell_pkg::csr_run, 32'd1);
      exp_profile = '0;
      for (int i = 0; i < 40; i++)
      begin
         a  = random_bits(32);
         av = random_bits(1);
         b  = random_bits(32);
         bv = random_bits(1);
         if (av)
            exp_profile[ref_model(kind_region, a, '0)] = 1'b1;
         if (bv)
            exp_profile[ref_model(kind_region, b, '0)] = 1'b1;
         drive_dram(a, av, b, bv);
      end
      drive_dram('0, 1'b0, '0, 1'b0);
      for (int i = 0; i < 4; i++)
         csr_expect("profile word", 3'd4 + i[2:0], exp_profile[32*i +: 32]);
      csr_write(zynq_shell_pkg::csr_run, 32'd0);
      for (int i = 0; i < 4; i++)
         csr_expect("profile word after core reset", 3'd4 + i[2:0], '0);
      finish_test();

      $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
               total_errors);
      if (total_errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: all.f
design/zynq_shell_pkg.sv
design/shell_csr_ctrl.sv
design/host_addr_xlate.sv
design/dram_addr_map.sv
design/mem_profiler.sv
design/zynq_shell_top.sv
verification/zynq_shell_tb.sv
